//--- Makefile
# Verilator build and run of the ADC array testbench

VERILATOR  ?= verilator
TOP        ?= adc_array_tb
DUT_TOP    ?= adc_array_top
FILELIST   ?= files.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  ?= All tests passed!
VFLAGS     ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES) adc_emu_params.svh
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	$(SIM_BIN) | tee $(LOG)
	@grep -qF '$(PASS_TEXT)' $(LOG) && echo "simulation passed" \
		|| (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(DUT_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- adc_array_tb.sv
`timescale 1ns/1ps
`include "adc_emu_params.svh"

module adc_array_tb;
    localparam int NS           = `ADC_NUM_SLICES;
    localparam int MAX_PHASES   = 32;
    localparam int DRAIN_CYCLES = 8;
    localparam int CNT_MAX      = (1 << `ADC_NDIV) - 1;
    localparam int MAG_MAX      = (1 << `ADC_MAG_BITS) - 1;
    localparam int DROP_MAX     = (1 << `CAP_DROP_BITS) - 1;

    logic                               emu_clk;
    logic                               reset;
    logic                               clk_in;
    logic                               en_sync_in;
    logic [NS-1:0][`ADC_VIN_BITS-1:0]   vin;
    adc_slice_pkg::slice_cfg_t [NS-1:0] cfg;
    logic                               capture_clear;
    logic [`CAP_ADDR_BITS-1:0]          rd_addr;
    logic [NS-1:0]                      clk_adder;
    logic [NS-1:0]                      en_sync_out;
    capture_pkg::cap_entry_t            rd_data;
    capture_pkg::cap_status_t           status;

    // phase table
    int         ph_vin [MAX_PHASES][NS];
    logic [3:0] ph_en [MAX_PHASES];
    logic [3:0] ph_alws [MAX_PHASES];
    int         ph_init [MAX_PHASES][NS];
    int         ph_amp [MAX_PHASES];
    int         ph_periods [MAX_PHASES];
    int         num_phases;

    // divider and enable model
    int          m_count [NS];
    int          m_conv [NS];
    logic        m_en;
    logic        m_en_out;
    logic [31:0] lcg_state;
    int          mismatches;
    int          failures;
    int          waited;

    adc_array_top uut (
        .emu_clk       (emu_clk),
        .reset         (reset),
        .clk_in        (clk_in),
        .en_sync_in    (en_sync_in),
        .vin           (vin),
        .cfg           (cfg),
        .capture_clear (capture_clear),
        .rd_addr       (rd_addr),
        .clk_adder     (clk_adder),
        .en_sync_out   (en_sync_out),
        .rd_data       (rd_data),
        .status        (status)
    );

    initial begin
        emu_clk = 1'b0;
        forever #20 emu_clk = ~emu_clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // limit a signed code to what sign and magnitude can hold
    function automatic int clip_code(input int v);
        if (v > MAG_MAX) begin
            return MAG_MAX;
        end
        if (v < -MAG_MAX) begin
            return -MAG_MAX;
        end
        return v;
    endfunction

    // signed code as it appears on the vin port
    function automatic int port_code(input int v);
        logic signed [`ADC_VIN_BITS-1:0] c;
        c = v[`ADC_VIN_BITS-1:0];
        return int'(c);
    endfunction

    task automatic report_mismatch(input string name, input int got, input int exp);
        mismatches++;
        $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
    endtask

    task automatic load_stimulus();
        int    fd;
        int    n;
        int    v0, v1, v2, v3, en, alws, i0, i1, i2, i3, amp, per;
        string line;
        num_phases = 0;
        fd = $fopen("adc_stimulus.txt", "r");
        if (fd == 0) begin
            failures++;
            $display("could not open the stimulus file adc_stimulus.txt");
        end else begin
            while (!$feof(fd) && num_phases < MAX_PHASES) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%d %d %d %d %b %b %d %d %d %d %d %d",
                                v0, v1, v2, v3, en, alws, i0, i1, i2, i3, amp, per);
                    if (n == 12) begin
                        ph_vin[num_phases]     = '{v0, v1, v2, v3};
                        ph_init[num_phases]    = '{i0, i1, i2, i3};
                        ph_en[num_phases]      = en[3:0];
                        ph_alws[num_phases]    = alws[3:0];
                        ph_amp[num_phases]     = amp;
                        ph_periods[num_phases] = per;
                        num_phases++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // count forced to init while not synced, parked at all ones when always on
    task automatic settle_model();
        for (int i = 0; i < NS; i++) begin
            if (!(m_en && cfg[i].en_slice)) begin
                m_count[i] = int'(cfg[i].init);
            end else if (cfg[i].alws_on) begin
                m_count[i] = CNT_MAX;
            end
        end
    endtask

    task automatic check_divider();
        logic exp_adder;
        for (int i = 0; i < NS; i++) begin
            exp_adder = ~m_count[i][`ADC_NDIV-1];
            if (clk_adder[i] != exp_adder) begin
                report_mismatch($sformatf("clk_adder[%0d]", i), int'(clk_adder[i]),
                                int'(exp_adder));
            end
            if (en_sync_out[i] != m_en_out) begin
                report_mismatch($sformatf("en_sync_out[%0d]", i), int'(en_sync_out[i]),
                                int'(m_en_out));
            end
        end
    endtask

    task automatic check_status(input int exp_fill, input int exp_full, input int exp_drop);
        if (int'(status.fill) != exp_fill) begin
            report_mismatch("status.fill", int'(status.fill), exp_fill);
        end
        if (int'(status.full) != exp_full) begin
            report_mismatch("status.full", int'(status.full), exp_full);
        end
        if (int'(status.drop_count) != exp_drop) begin
            report_mismatch("status.drop_count", int'(status.drop_count), exp_drop);
        end
    endtask

    // one clk_in half period of four emu_clk cycles
    task automatic drive_clk_in(input logic level);
        @(negedge emu_clk);
        clk_in = level;
        if (level) begin
            m_en_out = m_en;
        end else begin
            for (int i = 0; i < NS; i++) begin
                if (m_en && cfg[i].en_slice && !cfg[i].alws_on) begin
                    if (m_count[i] == CNT_MAX) begin
                        m_conv[i]++;
                    end
                    m_count[i] = (m_count[i] + 1) % (CNT_MAX + 1);
                end
            end
            m_en = en_sync_in;
            settle_model();
        end
        repeat (3) @(negedge emu_clk);
        check_divider();
    endtask

    task automatic apply_phase(input int p);
        @(negedge emu_clk);
        for (int i = 0; i < NS; i++) begin
            vin[i]           = ph_vin[p][i][`ADC_VIN_BITS-1:0];
            cfg[i].en_slice  = ph_en[p][i];
            cfg[i].alws_on   = ph_alws[p][i];
            cfg[i].init      = ph_init[p][i][`ADC_NDIV-1:0];
            cfg[i].noise_amp = ph_amp[p][`ADC_NOISE_AMP_BITS-1:0];
        end
        settle_model();
    endtask

    task automatic check_entries(input int p, input int n, input bit count_exact);
        int seen [NS];
        int id;
        int code;
        int amp;
        int got;
        amp = ph_amp[p];
        for (int i = 0; i < NS; i++) begin
            seen[i] = 0;
        end
        for (int a = 0; a < n; a++) begin
            @(negedge emu_clk);
            rd_addr = a[`CAP_ADDR_BITS-1:0];
            @(negedge emu_clk);
            id = int'(rd_data.slice_id);
            seen[id]++;
            code = port_code(ph_vin[p][id]);
            got = rd_data.result.sign ? -int'(rd_data.result.mag) : int'(rd_data.result.mag);
            if (amp == 0) begin
                if (int'(rd_data.result.sign) != int'(code < 0)) begin
                    report_mismatch("rd_data.result.sign", int'(rd_data.result.sign),
                                    int'(code < 0));
                end
                if (int'(rd_data.result.mag) != clip_code(code < 0 ? -code : code)) begin
                    report_mismatch("rd_data.result.mag", int'(rd_data.result.mag),
                                    clip_code(code < 0 ? -code : code));
                end
            end else if (got < clip_code(code - amp) || got > clip_code(code + amp)) begin
                mismatches++;
                $display("ERR %0t rd_data.result got %0d expected %0d within %0d",
                         $time, got, clip_code(code), amp);
            end
        end
        if (count_exact) begin
            for (int i = 0; i < NS; i++) begin
                if (seen[i] != m_conv[i]) begin
                    report_mismatch($sformatf("entries with slice_id %0d", i), seen[i],
                                    m_conv[i]);
                end
            end
        end
    endtask

    task automatic run_phase(input int p);
        int total;
        int exp_fill;
        int exp_drop;
        int cycles;
        apply_phase(p);
        capture_clear = 1'b1;
        @(negedge emu_clk);
        capture_clear = 1'b0;
        for (int i = 0; i < NS; i++) begin
            m_conv[i] = 0;
        end
        for (int k = 0; k < ph_periods[p]; k++) begin
            drive_clk_in(1'b1);
            drive_clk_in(1'b0);
        end
        total = 0;
        for (int i = 0; i < NS; i++) begin
            total += m_conv[i];
        end
        exp_fill = (total < `CAP_DEPTH) ? total : `CAP_DEPTH;
        exp_drop = (total - exp_fill > DROP_MAX) ? DROP_MAX : total - exp_fill;
        // arbiter drain
        cycles = 0;
        while ((int'(status.fill) != exp_fill || int'(status.drop_count) != exp_drop)
               && cycles < DRAIN_CYCLES) begin
            @(negedge emu_clk);
            cycles++;
        end
        if (int'(status.fill) != exp_fill || int'(status.drop_count) != exp_drop) begin
            failures++;
            $display("phase %0d: capture memory did not settle within %0d cycles",
                     p, DRAIN_CYCLES);
        end
        check_status(exp_fill, int'(total >= `CAP_DEPTH), exp_drop);
        check_entries(p, exp_fill, total <= `CAP_DEPTH);
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        reset         = 1'b1;
        clk_in        = 1'b0;
        en_sync_in    = 1'b0;
        vin           = '0;
        cfg           = '0;
        capture_clear = 1'b0;
        rd_addr       = '0;
        mismatches    = 0;
        failures      = 0;
        m_en          = 1'b0;
        m_en_out      = 1'b0;
        lcg_state     = 32'd90;
        load_stimulus();
        if (num_phases == 0) begin
            failures++;
            $display("no phases found in the stimulus file");
        end
        // LFSR seeds load during reset
        for (int i = 0; i < NS; i++) begin
            lcg_state = lcg_next(lcg_state);
            cfg[i].noise_seed = lcg_state[26:16];
        end
        if (num_phases > 0) begin
            apply_phase(0);
        end
        repeat (16) @(posedge emu_clk);
        @(negedge emu_clk);
        reset = 1'b0;
        @(negedge emu_clk);
        check_divider();
        check_status(0, 0, 0);

        // enable seen at a clk_in fall, published at the following rise
        en_sync_in = 1'b1;
        drive_clk_in(1'b1);
        drive_clk_in(1'b0);
        @(negedge emu_clk);
        clk_in = 1'b1;
        m_en_out = m_en;
        waited = 0;
        while (en_sync_out != '1 && waited < 4) begin
            @(negedge emu_clk);
            waited++;
        end
        if (en_sync_out != '1) begin
            failures++;
            $display("en_sync_out did not rise within 4 cycles of the clk_in rise");
        end

        for (int p = 0; p < num_phases; p++) begin
            run_phase(p);
        end

        $display("mismatches: %0d, other failures: %0d", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end
endmodule

//--- adc_array_top.sv
`timescale 1ns/1ps
`include "adc_emu_params.svh"

module adc_array_top (
    input  logic                                            emu_clk,
    input  logic                                            reset,
    input  logic                                            clk_in,
    input  logic                                            en_sync_in,
    input  logic [`ADC_NUM_SLICES-1:0][`ADC_VIN_BITS-1:0]   vin,
    input  adc_slice_pkg::slice_cfg_t [`ADC_NUM_SLICES-1:0] cfg,
    input  logic                                            capture_clear,
    input  logic [`CAP_ADDR_BITS-1:0]                       rd_addr,
    output logic [`ADC_NUM_SLICES-1:0]                      clk_adder,
    output logic [`ADC_NUM_SLICES-1:0]                      en_sync_out,
    output capture_pkg::cap_entry_t                         rd_data,
    output capture_pkg::cap_status_t                        status
);
    logic [`ADC_NUM_SLICES-1:0]                        sample_valid;
    adc_slice_pkg::slice_result_t [`ADC_NUM_SLICES-1:0] results;
    logic                                              wr_en;
    capture_pkg::cap_entry_t                           wr_entry;

    //////////////////////////////////////////////////////////////////////
    // slices
    //////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < `ADC_NUM_SLICES; i++) begin : g_slice
        // codes arrive as two's complement
        adc_slice u_slice (
            .emu_clk      (emu_clk),
            .reset        (reset),
            .clk_in       (clk_in),
            .en_sync_in   (en_sync_in),
            .vin          ($signed(vin[i])),
            .cfg          (cfg[i]),
            .clk_adder    (clk_adder[i]),
            .en_sync_out  (en_sync_out[i]),
            .sample_valid (sample_valid[i]),
            .result       (results[i])
        );
    end

    //////////////////////////////////////////////////////////////////////
    // shared capture path
    //////////////////////////////////////////////////////////////////////

    capture_arbiter u_arbiter (
        .emu_clk      (emu_clk),
        .reset        (reset),
        .sample_valid (sample_valid),
        .results      (results),
        .wr_en        (wr_en),
        .wr_entry     (wr_entry)
    );

    capture_ram u_ram (
        .emu_clk  (emu_clk),
        .reset    (reset),
        .clear    (capture_clear),
        .wr_en    (wr_en),
        .wr_entry (wr_entry),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .status   (status)
    );
endmodule

//--- adc_emu_params.svh
`ifndef ADC_EMU_PARAMS_SVH
`define ADC_EMU_PARAMS_SVH

// slice array
`define ADC_NUM_SLICES      4
`define ADC_SLICE_ID_BITS   2

// divider and conversion codes
`define ADC_NDIV            2
`define ADC_VIN_BITS        10
`define ADC_MAG_BITS        8
`define ADC_NOISE_AMP_BITS  3
`define ADC_SEED_BITS       11

// capture memory
`define CAP_DEPTH           64
`define CAP_ADDR_BITS       6
`define CAP_DROP_BITS       8

`endif

//--- adc_slice.sv
`timescale 1ns/1ps
`include "adc_emu_params.svh"

module adc_slice (
    input  logic                            emu_clk,
    input  logic                            reset,
    input  logic                            clk_in,
    input  logic                            en_sync_in,
    input  logic signed [`ADC_VIN_BITS-1:0] vin,
    input  adc_slice_pkg::slice_cfg_t       cfg,
    output logic                            clk_adder,
    output logic                            en_sync_out,
    output logic                            sample_valid,
    output adc_slice_pkg::slice_result_t    result
);
    logic                           clk_in_q;
    logic                           clk_in_qq;
    logic                           clk_in_rise;
    logic                           clk_in_fall;
    logic                           en_sampled;
    logic                           en_sync;
    logic [`ADC_NDIV-1:0]           count;
    logic                           wrap;
    logic signed [3:0]              dither;
    logic signed [`ADC_VIN_BITS:0]  sum;
    logic [`ADC_VIN_BITS:0]         abs_sum;
    adc_slice_pkg::slice_result_t   quant;

    //////////////////////////////////////////////////////////////////////
    // clk_in edge detection
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge emu_clk) begin
        if (reset) begin
            clk_in_q  <= 1'b0;
            clk_in_qq <= 1'b0;
        end else begin
            clk_in_q  <= clk_in;
            clk_in_qq <= clk_in_q;
        end
    end

    // edges show up one cycle after clk_in moves
    assign clk_in_rise = clk_in_q & ~clk_in_qq;
    assign clk_in_fall = ~clk_in_q & clk_in_qq;

    //////////////////////////////////////////////////////////////////////
    // enable synchronizer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge emu_clk) begin
        if (reset) begin
            en_sampled  <= 1'b0;
            en_sync_out <= 1'b0;
        end else begin
            // sample on the falling edge, publish on the rising edge
            if (clk_in_fall) begin
                en_sampled <= en_sync_in;
            end
            if (clk_in_rise) begin
                en_sync_out <= en_sampled;
            end
        end
    end

    assign en_sync = en_sampled & cfg.en_slice;

    //////////////////////////////////////////////////////////////////////
    // clock divider
    //////////////////////////////////////////////////////////////////////

    // all ones rolling over to zero is the rising edge of clk_adder
    assign wrap = clk_in_fall & en_sync & ~cfg.alws_on & (&count);

    always_ff @(posedge emu_clk) begin
        if (reset || !en_sync) begin
            count <= cfg.init;
        end else if (cfg.alws_on) begin
            count <= '1;
        end else if (clk_in_fall) begin
            count <= count + 1'b1;
        end
    end

    assign clk_adder = ~count[`ADC_NDIV-1];

    //////////////////////////////////////////////////////////////////////
    // dithered quantizer
    //////////////////////////////////////////////////////////////////////

    noise_lfsr u_noise (
        .emu_clk (emu_clk),
        .reset   (reset),
        .seed    (cfg.noise_seed),
        .amp     (cfg.noise_amp),
        .step    (wrap),
        .dither  (dither)
    );

    assign sum = vin + dither;
    assign abs_sum = sum[`ADC_VIN_BITS] ? $unsigned(-sum) : $unsigned(sum);

    always_comb begin
        quant.sign = sum[`ADC_VIN_BITS];
        // clip anything past the magnitude range to full scale
        if (|abs_sum[`ADC_VIN_BITS:`ADC_MAG_BITS]) begin
            quant.mag = '1;
        end else begin
            quant.mag = abs_sum[`ADC_MAG_BITS-1:0];
        end
    end

    always_ff @(posedge emu_clk) begin
        if (reset) begin
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= wrap;
        end
    end

    // result held until the next conversion
    always_ff @(posedge emu_clk) begin
        if (wrap) begin
            result <= quant;
        end
    end
endmodule

//--- adc_slice_pkg.sv
`include "adc_emu_params.svh"

package adc_slice_pkg;

    //////////////////////////////////////////////////////////////////////
    // per-slice configuration
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        // slice takes part in the array
        logic                           en_slice;
        // divider parked at all ones, no conversions
        logic                           alws_on;
        // divider start value while not synced
        logic [`ADC_NDIV-1:0]           init;
        // dither bound in codes, 0 turns dither off
        logic [`ADC_NOISE_AMP_BITS-1:0] noise_amp;
        logic [`ADC_SEED_BITS-1:0]      noise_seed;
    } slice_cfg_t;

    //////////////////////////////////////////////////////////////////////
    // conversion result
    //////////////////////////////////////////////////////////////////////

    // sign and saturated magnitude
    typedef struct packed {
        logic                     sign;
        logic [`ADC_MAG_BITS-1:0] mag;
    } slice_result_t;

endpackage

//--- adc_stimulus.txt
# vin0 vin1 vin2 vin3 en_slice alws_on init0 init1 init2 init3 noise_amp clk_in_periods
# vin is a signed decimal code, en_slice and alws_on are binary masks with slice 3 leftmost
100 -100 0 -1 1111 0000 0 1 2 3 0 24
255 256 -255 -256 1111 0000 3 2 1 0 0 20
511 -512 300 -400 1111 0000 0 0 0 0 0 16
# slices 1 and 3 disabled
37 -58 120 -7 0101 0000 2 3 0 1 0 24
# slices 1 and 2 parked by alws_on
12 34 -56 78 1111 0110 0 0 0 0 0 24
# dithered conversions
5 -3 250 -252 1111 0000 1 2 3 0 3 32
0 1 -1 254 1111 0000 0 0 0 0 7 40
# more than 64 conversions
200 -150 60 -600 1111 0000 0 1 2 3 0 120
-20 480 -255 9 1111 0000 0 0 0 0 2 340
10 20 30 40 1111 0000 1 1 1 1 1 12
# all slices off
50 -50 50 -50 0000 0000 3 1 2 0 0 16

//--- capture_arbiter.sv
`timescale 1ns/1ps
`include "adc_emu_params.svh"

module capture_arbiter (
    input  logic                                              emu_clk,
    input  logic                                              reset,
    input  logic [`ADC_NUM_SLICES-1:0]                        sample_valid,
    input  adc_slice_pkg::slice_result_t [`ADC_NUM_SLICES-1:0] results,
    output logic                                              wr_en,
    output capture_pkg::cap_entry_t                           wr_entry
);
    localparam int N    = `ADC_NUM_SLICES;
    localparam int ID_W = `ADC_SLICE_ID_BITS;

    logic [N-1:0]                         pending;
    logic [N-1:0]                         req;
    adc_slice_pkg::slice_result_t [N-1:0] held;
    logic [ID_W-1:0]                      last_grant;
    logic [ID_W-1:0]                      cand;
    logic [ID_W-1:0]                      grant_id;
    logic                                 grant_valid;

    // a fresh strobe competes in its own cycle
    assign req = pending | sample_valid;

    // search starts one past the last winner
    always_comb begin
        grant_valid = 1'b0;
        grant_id    = last_grant;
        cand        = last_grant;
        for (int i = 1; i <= N; i++) begin
            cand = last_grant + ID_W'(i);
            if (!grant_valid && req[cand]) begin
                grant_valid = 1'b1;
                grant_id    = cand;
            end
        end
    end

    always_ff @(posedge emu_clk) begin
        if (reset) begin
            pending    <= '0;
            last_grant <= ID_W'(N - 1);
            wr_en      <= 1'b0;
        end else begin
            for (int i = 0; i < N; i++) begin
                if (grant_valid && grant_id == ID_W'(i)) begin
                    pending[i] <= 1'b0;
                end else if (sample_valid[i]) begin
                    pending[i] <= 1'b1;
                end
            end
            wr_en <= grant_valid;
            if (grant_valid) begin
                last_grant <= grant_id;
            end
        end
    end

    always_ff @(posedge emu_clk) begin
        for (int i = 0; i < N; i++) begin
            if (sample_valid[i]) begin
                held[i] <= results[i];
            end
        end
        if (grant_valid) begin
            wr_entry.slice_id <= grant_id;
            wr_entry.result   <= sample_valid[grant_id] ? results[grant_id] : held[grant_id];
        end
    end
endmodule

//--- capture_pkg.sv
`include "adc_emu_params.svh"

package capture_pkg;

    //////////////////////////////////////////////////////////////////////
    // memory entry
    //////////////////////////////////////////////////////////////////////

    // one stored conversion, tagged with the slice it came from
    typedef struct packed {
        logic [`ADC_SLICE_ID_BITS-1:0] slice_id;
        adc_slice_pkg::slice_result_t  result;
    } cap_entry_t;

    //////////////////////////////////////////////////////////////////////
    // readout status
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        // entries written since the last clear
        logic [`CAP_ADDR_BITS:0]   fill;
        // no room left, further writes are dropped
        logic                      full;
        // saturating count of dropped writes
        logic [`CAP_DROP_BITS-1:0] drop_count;
    } cap_status_t;

endpackage

//--- capture_ram.sv
`timescale 1ns/1ps
`include "adc_emu_params.svh"

module capture_ram (
    input  logic                       emu_clk,
    input  logic                       reset,
    input  logic                       clear,
    input  logic                       wr_en,
    input  capture_pkg::cap_entry_t    wr_entry,
    input  logic [`CAP_ADDR_BITS-1:0]  rd_addr,
    output capture_pkg::cap_entry_t    rd_data,
    output capture_pkg::cap_status_t   status
);
    localparam logic [`CAP_ADDR_BITS:0] FILL_MAX = `CAP_DEPTH;

    capture_pkg::cap_entry_t     mem [`CAP_DEPTH];
    logic [`CAP_ADDR_BITS:0]     fill;
    logic                        full;
    logic [`CAP_DROP_BITS-1:0]   drop_count;

    assign full = (fill == FILL_MAX);

    //////////////////////////////////////////////////////////////////////
    // write pointer and drop counter
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge emu_clk) begin
        if (reset || clear) begin
            fill       <= '0;
            drop_count <= '0;
        end else if (wr_en) begin
            if (!full) begin
                fill <= fill + 1'b1;
            end else if (drop_count != '1) begin
                // saturates at all ones
                drop_count <= drop_count + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // storage and read port
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge emu_clk) begin
        // fill doubles as the write address
        if (wr_en && !full && !clear) begin
            mem[fill[`CAP_ADDR_BITS-1:0]] <= wr_entry;
        end
        rd_data <= mem[rd_addr];
    end

    always_comb begin
        status.fill       = fill;
        status.full       = full;
        status.drop_count = drop_count;
    end
endmodule

//--- files.f
+incdir+.
adc_slice_pkg.sv
capture_pkg.sv
noise_lfsr.sv
adc_slice.sv
capture_arbiter.sv
capture_ram.sv
adc_array_top.sv
adc_array_tb.sv

//--- noise_lfsr.sv
`timescale 1ns/1ps
`include "adc_emu_params.svh"

module noise_lfsr (
    input  logic                           emu_clk,
    input  logic                           reset,
    input  logic [`ADC_SEED_BITS-1:0]      seed,
    input  logic [`ADC_NOISE_AMP_BITS-1:0] amp,
    input  logic                           step,
    output logic signed [3:0]              dither
);
    // x^16 + x^14 + x^13 + x^11 + 1, right shifting Galois form
    localparam logic [15:0] TAPS = 16'hb400;

    logic [15:0]       lfsr;
    logic [4:0]        span;
    logic [3:0]        folded;
    logic signed [4:0] centered;

    always_ff @(posedge emu_clk) begin
        if (reset) begin
            // bit 0 forced high so the state never starts at zero
            lfsr <= {4'b1010, seed, 1'b1};
        end else if (step) begin
            lfsr <= {1'b0, lfsr[15:1]} ^ (lfsr[0] ? TAPS : 16'h0000);
        end
    end

    // 2*amp+1 possible values
    assign span = {amp, 1'b1};
    assign folded = 4'(lfsr[7:0] % {3'b000, span});

    // shift down so the range is centred on zero
    assign centered = $signed({1'b0, folded}) - $signed({2'b00, amp});
    assign dither = centered[3:0];
endmodule
